/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o tb_rv_core

out=$(./obj_dir/tb_rv_core)
echo "$out"

# Pass only when the testbench reports it
echo "$out" | grep -qx "test passed"

/* rv_core.f */
src/rv_core_pkg.sv
src/stage_control.sv
src/instr_decode.sv
src/alu.sv
src/register_file.sv
src/rv_core.sv
test/tb_rv_core.sv
test/rv_core_properties.sv

/* src/alu.sv */
`timescale 1ns/100ps

module alu import rv_core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    i_execute_en,
    input  alu_op_t i_alu_op,
    input  word_t   i_rs1_data,
    input  word_t   i_rs2_data,
    input  word_t   i_imm,
    input  logic    i_use_imm,
    output word_t   o_result
);

    // Second operand, immediate or rs2
    word_t operand_b;

    // Shift amount, low 5 bits only
    logic [4:0] shamt;

    // Unregistered result
    word_t result_next;

    assign operand_b = i_use_imm ? i_imm : i_rs2_data;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (i_alu_op)
            ALU_ADD:  result_next = i_rs1_data + operand_b;
            ALU_SUB:  result_next = i_rs1_data - operand_b;
            ALU_AND:  result_next = i_rs1_data & operand_b;
            ALU_OR:   result_next = i_rs1_data | operand_b;
            ALU_XOR:  result_next = i_rs1_data ^ operand_b;
            ALU_SLL:  result_next = i_rs1_data << shamt;
            ALU_SRL:  result_next = i_rs1_data >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  result_next = word_t'($signed(i_rs1_data) >>> shamt);
            // Signed compare
            ALU_SLT: begin
                result_next = ($signed(i_rs1_data) < $signed(operand_b)) ? 32'd1 : 32'd0;
            end
            // Unsigned compare, SLTIU sees the sign-extended immediate
            ALU_SLTU: begin
                result_next = (i_rs1_data < operand_b) ? 32'd1 : 32'd0;
            end
            default:  result_next = '0;
        endcase
    end

    // Result held from execute through writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            o_result <= '0;
        end else if (i_execute_en) begin
            o_result <= result_next;
        end
    end

endmodule

/* src/instr_decode.sv */
`timescale 1ns/100ps

module instr_decode import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_load_instr,
    input  logic       i_decode_en,
    input  instr_t     i_imem_data,
    output reg_index_t o_rs1_addr,
    output reg_index_t o_rs2_addr,
    output reg_index_t o_rd_addr,
    output alu_op_t    o_alu_op,
    output word_t      o_imm,
    output logic       o_use_imm,
    output logic       o_writes_rd
);

    // Fetched word, held until the next accept
    instr_t instr;

    // Field views of the latched word
    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_op;
    logic    is_op_imm;

    // Decoded operation before registering
    alu_op_t op_next;

    always_ff @(posedge clk) begin
        if (i_load_instr) begin
            instr <= i_imem_data;
        end
    end

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    // For shift immediates this is imm[11:5]
    assign funct7    = instr[31:25];
    assign is_op     = (opcode == OPCODE_OP);
    assign is_op_imm = (opcode == OPCODE_OP_IMM);

    // Register reads start right after the latch edge
    assign o_rs1_addr = instr[19:15];
    // Immediate forms carry imm bits here, not a register
    assign o_rs2_addr = is_op_imm ? REG_ZERO : instr[24:20];

    // Operation select from opcode, funct3 and funct7
    always_comb begin
        op_next = ALU_NONE;
        case (funct3)
            FUNCT3_ADD_SUB: begin
                if (is_op_imm || (is_op && funct7 == FUNCT7_BASE)) begin
                    op_next = ALU_ADD;
                end else if (is_op && funct7 == FUNCT7_ALT) begin
                    op_next = ALU_SUB;
                end
            end
            FUNCT3_SRL_SRA: begin
                if (funct7 == FUNCT7_BASE) begin
                    op_next = ALU_SRL;
                end else if (funct7 == FUNCT7_ALT) begin
                    op_next = ALU_SRA;
                end
            end
            // SLL needs a base funct7 in both forms
            FUNCT3_SLL:  op_next = (funct7 == FUNCT7_BASE) ? ALU_SLL : ALU_NONE;
            FUNCT3_SLT:  op_next = (is_op_imm || funct7 == FUNCT7_BASE) ? ALU_SLT : ALU_NONE;
            FUNCT3_SLTU: op_next = (is_op_imm || funct7 == FUNCT7_BASE) ? ALU_SLTU : ALU_NONE;
            FUNCT3_XOR:  op_next = (is_op_imm || funct7 == FUNCT7_BASE) ? ALU_XOR : ALU_NONE;
            FUNCT3_OR:   op_next = (is_op_imm || funct7 == FUNCT7_BASE) ? ALU_OR : ALU_NONE;
            FUNCT3_AND:  op_next = (is_op_imm || funct7 == FUNCT7_BASE) ? ALU_AND : ALU_NONE;
            default:     op_next = ALU_NONE;
        endcase
        // Other opcodes are not executed
        if (!is_op && !is_op_imm) begin
            op_next = ALU_NONE;
        end
    end

    // Operation and write flag, registered in decode
    always_ff @(posedge clk) begin
        if (reset) begin
            o_alu_op    <= ALU_NONE;
            o_writes_rd <= 1'b0;
        end else if (i_decode_en) begin
            o_alu_op    <= op_next;
            o_writes_rd <= (op_next != ALU_NONE);
        end
    end

    // Immediate, operand select and destination
    always_ff @(posedge clk) begin
        if (i_decode_en) begin
            o_imm     <= {{(XLEN-12){instr[31]}}, instr[31:20]};
            o_use_imm <= is_op_imm;
            o_rd_addr <= instr[11:7];
        end
    end

endmodule

/* src/register_file.sv */
`timescale 1ns/100ps

module register_file import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  reg_index_t i_rs1_addr,
    input  reg_index_t i_rs2_addr,
    input  reg_index_t i_rd_addr,
    input  word_t      i_rd_data,
    input  logic       i_write_enable,
    output word_t      o_rs1_data,
    output word_t      o_rs2_data
);

    // Register array
    word_t regs [REG_COUNT];

    // Write port, x0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write_enable && i_rd_addr != REG_ZERO) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // Both read ports registered every cycle
    // x0 reads back as zero
    always_ff @(posedge clk) begin
        o_rs1_data <= (i_rs1_addr == REG_ZERO) ? '0 : regs[i_rs1_addr];
        o_rs2_data <= (i_rs2_addr == REG_ZERO) ? '0 : regs[i_rs2_addr];
    end

endmodule

/* src/rv_core.sv */
`timescale 1ns/100ps

module rv_core import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  word_t      i_reset_pc,
    input  logic       i_imem_valid,
    input  instr_t     i_imem_data,
    output logic       o_imem_valid,
    output word_t      o_imem_addr,
    output logic       o_rd_write_enable,
    output reg_index_t o_rd_addr,
    output word_t      o_rd_data
);

    // Stage strobes
    logic load_instr;
    logic decode_en;
    logic execute_en;

    // Decode outputs
    reg_index_t rs1_addr;
    reg_index_t rs2_addr;
    alu_op_t    alu_op;
    word_t      imm;
    logic       use_imm;
    logic       writes_rd;

    // Register read data
    word_t rs1_data;
    word_t rs2_data;

    stage_control stage_control0 (
        .clk               (clk),
        .reset             (reset),
        .i_reset_pc        (i_reset_pc),
        .i_imem_valid      (i_imem_valid),
        .i_writes_rd       (writes_rd),
        .o_imem_valid      (o_imem_valid),
        .o_imem_addr       (o_imem_addr),
        .o_load_instr      (load_instr),
        .o_decode_en       (decode_en),
        .o_execute_en      (execute_en),
        .o_rd_write_enable (o_rd_write_enable)
    );

    instr_decode instr_decode0 (
        .clk          (clk),
        .reset        (reset),
        .i_load_instr (load_instr),
        .i_decode_en  (decode_en),
        .i_imem_data  (i_imem_data),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .o_rd_addr    (o_rd_addr),
        .o_alu_op     (alu_op),
        .o_imm        (imm),
        .o_use_imm    (use_imm),
        .o_writes_rd  (writes_rd)
    );

    alu alu0 (
        .clk          (clk),
        .reset        (reset),
        .i_execute_en (execute_en),
        .i_alu_op     (alu_op),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_imm        (imm),
        .i_use_imm    (use_imm),
        .o_result     (o_rd_data)
    );

    // Write port shared with the writeback trace outputs
    register_file register_file0 (
        .clk            (clk),
        .reset          (reset),
        .i_rs1_addr     (rs1_addr),
        .i_rs2_addr     (rs2_addr),
        .i_rd_addr      (o_rd_addr),
        .i_rd_data      (o_rd_data),
        .i_write_enable (o_rd_write_enable),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data)
    );

endmodule

/* src/rv_core_pkg.sv */
package rv_core_pkg;

    // Datapath and address width
    localparam int XLEN = 32;

    // Architectural register count, x0 included
    localparam int REG_COUNT = 32;

    // Data word and program counter
    typedef logic [XLEN-1:0] word_t;

    // Raw 32-bit instruction word
    typedef logic [31:0] instr_t;

    // Register number, wide enough for every register
    typedef logic [$clog2(REG_COUNT)-1:0] reg_index_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // PC increment per instruction, one word
    localparam word_t PC_STEP = 32'd4;

    // Hard-wired zero register
    localparam reg_index_t REG_ZERO = '0;

    // Only the two ALU instruction classes are supported
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;

    // funct3 codes, shared by register and immediate forms
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    // funct7 codes
    // Base picks ADD and SRL, alternate picks SUB and SRA
    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;

    // ALU operation, one code per function
    // Immediate forms reuse the register form code
    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // Multi-cycle stage sequence
    // One instruction in flight at a time
    typedef enum logic [1:0] {
        STAGE_FETCH,
        STAGE_DECODE,
        STAGE_EXECUTE,
        STAGE_WRITEBACK
    } stage_t;

endpackage

/* src/stage_control.sv */
`timescale 1ns/100ps

module stage_control import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t i_reset_pc,
    input  logic  i_imem_valid,
    input  logic  i_writes_rd,
    output logic  o_imem_valid,
    output word_t o_imem_addr,
    output logic  o_load_instr,
    output logic  o_decode_en,
    output logic  o_execute_en,
    output logic  o_rd_write_enable
);

    // Current stage
    stage_t stage;

    // Program counter
    word_t pc;

    // Accept happens on the edge where memory answers in fetch
    logic accept;
    assign accept = (stage == STAGE_FETCH) && i_imem_valid;

    // Stage sequencing
    // Fetch holds until memory answers, the rest take one cycle each
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_FETCH;
        end else begin
            case (stage)
                STAGE_FETCH: begin
                    if (accept) begin
                        stage <= STAGE_DECODE;
                    end
                end
                STAGE_DECODE:    stage <= STAGE_EXECUTE;
                STAGE_EXECUTE:   stage <= STAGE_WRITEBACK;
                STAGE_WRITEBACK: stage <= STAGE_FETCH;
                default:         stage <= STAGE_FETCH;
            endcase
        end
    end

    // PC steps on the edge that leaves writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= i_reset_pc;
        end else if (stage == STAGE_WRITEBACK) begin
            pc <= pc + PC_STEP;
        end
    end

    // Fetch request is a level for the whole fetch stage
    assign o_imem_valid = (stage == STAGE_FETCH);
    assign o_imem_addr  = pc;

    // One strobe per stage
    assign o_load_instr = accept;
    assign o_decode_en  = (stage == STAGE_DECODE);
    assign o_execute_en = (stage == STAGE_EXECUTE);

    // Write only when decode found a writing instruction
    // Includes rd of x0, the register file drops that write
    assign o_rd_write_enable = (stage == STAGE_WRITEBACK) && i_writes_rd;

endmodule

/* test/rv_core_properties.sv */
`timescale 1ns/100ps

module rv_core_properties import rv_core_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  i_mem_valid,
    input logic  i_fetch_req,
    input word_t i_fetch_addr,
    input logic  i_rd_write_enable
);

    // Instruction taken on this edge
    logic accept;
    assign accept = i_fetch_req && i_mem_valid;

    // Stalled request keeps its address
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        (i_fetch_req && !i_mem_valid) |=> $stable(i_fetch_addr))
        else $error("fetch address moved during a stall");

    // Decode, execute and writeback make no request
    fetch_gap: assert property (@(posedge clk) disable iff (reset)
        ($past(accept) || $past(accept, 2) || $past(accept, 3)) |-> !i_fetch_req)
        else $error("fetch request inside the 3 cycles after accept");

    single_write: assert property (@(posedge clk) disable iff (reset)
        i_rd_write_enable |=> !i_rd_write_enable)
        else $error("write enable high on two cycles in a row");

    write_not_fetch: assert property (@(posedge clk) disable iff (reset)
        !(i_rd_write_enable && i_fetch_req))
        else $error("write enable high during fetch");

endmodule

bind rv_core rv_core_properties props0 (
    .clk               (clk),
    .reset             (reset),
    .i_mem_valid       (i_imem_valid),
    .i_fetch_req       (o_imem_valid),
    .i_fetch_addr      (o_imem_addr),
    .i_rd_write_enable (o_rd_write_enable)
);

/* test/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core import rv_core_pkg::*; ();

    // About 40 instructions at up to 9 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 1000;

    logic       clk = 1'b0;
    logic       reset;
    word_t      i_reset_pc;
    logic       i_imem_valid;
    instr_t     i_imem_data;
    logic       o_imem_valid;
    word_t      o_imem_addr;
    logic       o_rd_write_enable;
    reg_index_t o_rd_addr;
    word_t      o_rd_data;

    // Instruction memory, word index from the reset PC
    instr_t mem [64];
    // Program of the current test
    instr_t prog_q[$];
    // Written data per instruction, zero when nothing is written
    word_t  results_q[$];
    // Shadow copy of the architectural registers
    word_t  shadow [REG_COUNT];
    word_t  exp_pc;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     cycles = 0;

    rv_core dut0 (
        .clk               (clk),
        .reset             (reset),
        .i_reset_pc        (i_reset_pc),
        .i_imem_valid      (i_imem_valid),
        .i_imem_data       (i_imem_data),
        .o_imem_valid      (o_imem_valid),
        .o_imem_addr       (o_imem_addr),
        .o_rd_write_enable (o_rd_write_enable),
        .o_rd_addr         (o_rd_addr),
        .o_rd_data         (o_rd_data)
    );

    always #5 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    task automatic flag_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_reg_index(input string name, input reg_index_t exp,
                                     input reg_index_t act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s expected x%0d actual x%0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic summarize_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    // R-type and I-type encoders
    function automatic instr_t enc_r(funct7_t f7, reg_index_t rs2, reg_index_t rs1,
                                     funct3_t f3, reg_index_t rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_index_t rs1, funct3_t f3,
                                     reg_index_t rd);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    // ISA model of one instruction, updates the shadow registers
    task automatic ref_exec(input instr_t w, output logic wr, output reg_index_t rd,
                            output word_t data);
        opcode_t            op;
        funct3_t            f3;
        funct7_t            f7;
        word_t              a;
        word_t              b;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [4:0]         sh;
        begin
            op = w[6:0];
            f3 = w[14:12];
            f7 = w[31:25];
            rd = w[11:7];
            a  = shadow[w[19:15]];
            b  = (op == OPCODE_OP) ? shadow[w[24:20]] : {{20{w[31]}}, w[31:20]};
            sa = a;
            sb = b;
            sh = b[4:0];
            // Non-shift immediates ignore the top bits, SUB and SRA take the alternate code
            wr = (op == OPCODE_OP || op == OPCODE_OP_IMM) && (f7 == FUNCT7_BASE
                 || (op == OPCODE_OP_IMM && f3 != FUNCT3_SLL && f3 != FUNCT3_SRL_SRA)
                 || (f7 == FUNCT7_ALT && (f3 == FUNCT3_SRL_SRA
                     || (f3 == FUNCT3_ADD_SUB && op == OPCODE_OP))));
            case (f3)
                FUNCT3_ADD_SUB: data = (op == OPCODE_OP && f7 == FUNCT7_ALT) ? a - b : a + b;
                FUNCT3_SLL:     data = a << sh;
                FUNCT3_SLT:     data = (sa < sb) ? 32'd1 : 32'd0;
                FUNCT3_SLTU:    data = (a < b) ? 32'd1 : 32'd0;
                FUNCT3_XOR:     data = a ^ b;
                FUNCT3_SRL_SRA: begin
                    // Arithmetic shift fills with the sign bit
                    if (f7 == FUNCT7_ALT) begin
                        data = sa >>> sh;
                    end else begin
                        data = a >> sh;
                    end
                end
                FUNCT3_OR:      data = a | b;
                default:        data = a & b;
            endcase
            if (!wr) begin
                data = '0;
            end else if (rd != REG_ZERO) begin
                shadow[rd] = data;
            end
        end
    endtask

    // Memory answer for one fetch, then follow the instruction to the next fetch
    task automatic run_instr(input string name, input logic stalls);
        instr_t     w;
        logic [5:0] idx;
        int         stall;
        int         k;
        int         wr_k;
        int         fetch_k;
        logic       exp_wr;
        reg_index_t exp_rd;
        word_t      exp_data;
        reg_index_t got_rd;
        word_t      got_data;
        begin
            if (!o_imem_valid) begin
                flag_failure($sformatf("%s: core is not requesting a fetch", name));
            end
            compare_word(name, exp_pc, o_imem_addr);
            idx = 6'((o_imem_addr - i_reset_pc) >> 2);
            w = mem[idx];
            stall = stalls ? int'($urandom % 5) : 0;
            repeat (stall) @(negedge clk);
            i_imem_valid = 1'b1;
            i_imem_data  = w;
            ref_exec(w, exp_wr, exp_rd, exp_data);
            k = 0;
            wr_k = 0;
            fetch_k = 0;
            got_rd = '0;
            got_data = '0;
            // k counts edges from the accept edge
            while (fetch_k == 0 && k < 6) begin
                @(negedge clk);
                k++;
                if (k == 1) begin
                    i_imem_valid = 1'b0;
                    i_imem_data  = '0;
                end
                if (o_rd_write_enable) begin
                    if (wr_k != 0) begin
                        flag_failure($sformatf("%s: two write pulses for one instruction", name));
                    end
                    wr_k = k;
                    got_rd = o_rd_addr;
                    got_data = o_rd_data;
                end
                if (o_imem_valid) begin
                    fetch_k = k;
                end
            end
            compare_flag(name, exp_wr, wr_k != 0);
            if (exp_wr && wr_k != 0) begin
                compare_reg_index(name, exp_rd, got_rd);
                compare_word(name, exp_data, got_data);
                if (wr_k != 3) begin
                    flag_failure($sformatf("%s: write pulse %0d cycles after accept, not 2",
                                           name, wr_k - 1));
                end
            end
            if (fetch_k != 4) begin
                flag_failure($sformatf("%s: next fetch did not start 3 edges after accept",
                                       name));
            end
            exp_pc = exp_pc + PC_STEP;
            results_q.push_back(got_data);
        end
    endtask

    // Place the program at the current PC and run it
    task automatic run_program(input string name, input logic stalls);
        int base;
        begin
            base = int'((exp_pc - i_reset_pc) >> 2);
            for (int i = 0; i < prog_q.size(); i++) begin
                mem[base + i] = prog_q[i];
            end
            for (int i = 0; i < prog_q.size(); i++) begin
                run_instr(name, stalls);
            end
            prog_q.delete();
        end
    endtask

    task automatic reset_check;
        int err_start;
        begin
            err_start = errors;
            compare_flag("reset", 1'b1, o_imem_valid);
            compare_word("reset", i_reset_pc, o_imem_addr);
            compare_flag("reset", 1'b0, o_rd_write_enable);
            summarize_test("reset", err_start);
        end
    endtask

    task automatic reg_reg_ops;
        int err_start;
        begin
            err_start = errors;
            // Operands: x1 = -7, x2 = 100, x3 = 37 (shift of 5 after masking)
            prog_q.push_back(enc_i(12'hFF9, 5'd0, FUNCT3_ADD_SUB, 5'd1));
            prog_q.push_back(enc_i(12'd100, 5'd0, FUNCT3_ADD_SUB, 5'd2));
            prog_q.push_back(enc_i(12'd37, 5'd0, FUNCT3_ADD_SUB, 5'd3));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_ADD_SUB, 5'd5));
            prog_q.push_back(enc_r(FUNCT7_ALT, 5'd2, 5'd1, FUNCT3_ADD_SUB, 5'd6));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_AND, 5'd7));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_OR, 5'd8));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_XOR, 5'd9));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd3, 5'd2, FUNCT3_SLL, 5'd10));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd3, 5'd1, FUNCT3_SRL_SRA, 5'd11));
            prog_q.push_back(enc_r(FUNCT7_ALT, 5'd3, 5'd1, FUNCT3_SRL_SRA, 5'd12));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_SLT, 5'd13));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_SLTU, 5'd14));
            run_program("reg_reg_ops", 1'b1);
            summarize_test("reg_reg_ops", err_start);
        end
    endtask

    task automatic imm_ops;
        int err_start;
        begin
            err_start = errors;
            prog_q.push_back(enc_i(12'hF9C, 5'd1, FUNCT3_ADD_SUB, 5'd15));
            prog_q.push_back(enc_i(12'h0F0, 5'd1, FUNCT3_AND, 5'd16));
            prog_q.push_back(enc_i(12'hF00, 5'd2, FUNCT3_OR, 5'd17));
            prog_q.push_back(enc_i(12'hFFF, 5'd1, FUNCT3_XOR, 5'd18));
            prog_q.push_back(enc_i(12'hFF8, 5'd1, FUNCT3_SLT, 5'd19));
            // -1 sign-extends to the largest unsigned value
            prog_q.push_back(enc_i(12'hFFF, 5'd2, FUNCT3_SLTU, 5'd20));
            prog_q.push_back(enc_i({FUNCT7_BASE, 5'd7}, 5'd1, FUNCT3_SLL, 5'd21));
            prog_q.push_back(enc_i({FUNCT7_BASE, 5'd3}, 5'd1, FUNCT3_SRL_SRA, 5'd22));
            prog_q.push_back(enc_i({FUNCT7_ALT, 5'd3}, 5'd1, FUNCT3_SRL_SRA, 5'd23));
            run_program("imm_ops", 1'b1);
            summarize_test("imm_ops", err_start);
        end
    endtask

    task automatic zero_and_unknown;
        int err_start;
        begin
            err_start = errors;
            prog_q.push_back(enc_i(12'd5, 5'd0, FUNCT3_ADD_SUB, 5'd0));
            prog_q.push_back(enc_r(FUNCT7_BASE, 5'd0, 5'd0, FUNCT3_ADD_SUB, 5'd24));
            // LUI, outside the supported set
            prog_q.push_back(32'h123450B7);
            // MUL encoding, unknown funct7
            prog_q.push_back(enc_r(7'b0000001, 5'd2, 5'd1, FUNCT3_ADD_SUB, 5'd25));
            prog_q.push_back(enc_i(12'd1, 5'd0, FUNCT3_ADD_SUB, 5'd25));
            run_program("zero_and_unknown", 1'b1);
            summarize_test("zero_and_unknown", err_start);
        end
    endtask

    // Self-contained sequence, same results wherever it runs
    task automatic stall_program;
        prog_q.push_back(enc_i(12'hED4, 5'd0, FUNCT3_ADD_SUB, 5'd26));
        prog_q.push_back(enc_i(12'd9, 5'd0, FUNCT3_ADD_SUB, 5'd27));
        prog_q.push_back(enc_r(FUNCT7_ALT, 5'd27, 5'd26, FUNCT3_SRL_SRA, 5'd28));
        prog_q.push_back(enc_r(FUNCT7_BASE, 5'd27, 5'd26, FUNCT3_SLTU, 5'd29));
        prog_q.push_back(enc_r(FUNCT7_BASE, 5'd27, 5'd26, FUNCT3_XOR, 5'd30));
    endtask

    task automatic fetch_stalls;
        int    err_start;
        word_t flat_q[$];
        begin
            err_start = errors;
            results_q.delete();
            stall_program();
            run_program("fetch_stalls", 1'b0);
            flat_q = results_q;
            results_q.delete();
            stall_program();
            run_program("fetch_stalls", 1'b1);
            if (results_q.size() != flat_q.size()) begin
                flag_failure("fetch_stalls: stalled run gave a different number of results");
            end else begin
                foreach (flat_q[i]) begin
                    compare_word("fetch_stalls", flat_q[i], results_q[i]);
                end
            end
            summarize_test("fetch_stalls", err_start);
        end
    endtask

    initial begin
        void'($urandom(32'h9435));
        reset = 1'b1;
        i_reset_pc = 32'h0000_1000;
        i_imem_valid = 1'b0;
        i_imem_data = '0;
        exp_pc = i_reset_pc;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        reset_check();
        reg_reg_ops();
        imm_ops();
        zero_and_unknown();
        fetch_stalls();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
